/* axi_pkg.sv */
`default_nettype none

`include "pmem_params.svh"

package axi_pkg;

    // AxBURST encodings
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // BRESP / RRESP encodings
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // write address channel
    typedef struct packed {
        logic [`PMEM_ADDR_W-1:0] addr;
        logic [`PMEM_ID_W-1:0]   id;
        logic [7:0]              len;
        logic [2:0]              size;
        axi_burst_e              burst;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic [`PMEM_DATA_W-1:0]   data;
        logic [`PMEM_DATA_W/8-1:0] strb;
        logic                      last;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        logic [`PMEM_ID_W-1:0] id;
        axi_resp_e             resp;
    } axi_b_t;

    // read address channel, same layout as AW
    typedef struct packed {
        logic [`PMEM_ADDR_W-1:0] addr;
        logic [`PMEM_ID_W-1:0]   id;
        logic [7:0]              len;
        logic [2:0]              size;
        axi_burst_e              burst;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [`PMEM_DATA_W-1:0] data;
        logic [`PMEM_ID_W-1:0]   id;
        axi_resp_e               resp;
        logic                    last;
    } axi_r_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+.
axi_pkg.sv
pmem_pkg.sv
pmem_axi_slave.sv
pmem_sram.sv
pmem_top.sv
pmem_tb_clock.sv
pmem_tb.sv

/* pmem_axi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pmem_params.svh"

module pmem_axi_slave (
    input  wire logic                    clock,
    input  wire logic                    reset,

    input  wire axi_pkg::axi_aw_t        aw_i,
    input  wire logic                    aw_valid_i,
    output logic                         aw_ready_o,

    input  wire axi_pkg::axi_w_t         w_i,
    input  wire logic                    w_valid_i,
    output logic                         w_ready_o,

    output axi_pkg::axi_b_t              b_o,
    output logic                         b_valid_o,
    input  wire logic                    b_ready_i,

    input  wire axi_pkg::axi_ar_t        ar_i,
    input  wire logic                    ar_valid_i,
    output logic                         ar_ready_o,

    output axi_pkg::axi_r_t              r_o,
    output logic                         r_valid_o,
    input  wire logic                    r_ready_i,

    output pmem_pkg::pmem_req_t          req_o,
    input  wire logic [`PMEM_DATA_W-1:0] mem_rdata_i
);

    import axi_pkg::*;
    import pmem_pkg::*;

    // first byte address past the array
    localparam logic [`PMEM_ADDR_W-1:0] ADDR_LIMIT = `PMEM_ADDR_W'(`PMEM_DEPTH * 4);
    // the only AxSIZE supported is the full bus width
    localparam logic [2:0] FULL_SIZE = 3'($clog2(`PMEM_DATA_W / 8));

    pmem_state_e state;
    pmem_state_e state_next;

    // captured command
    logic [`PMEM_ADDR_W-1:0]   cmd_addr;
    logic [`PMEM_ID_W-1:0]     cmd_id;
    logic [7:0]                beats_left;
    logic [`PMEM_DATA_W-1:0]   wr_data;
    logic [`PMEM_DATA_W/8-1:0] wr_strb;

    // range decision for the current beat
    logic addr_ok;
    logic beat_ok;

    logic wr_accept;
    logic rd_accept;

    // write needs both AW and W, and beats a pending read
    assign wr_accept = (state == IDLE) && aw_valid_i && w_valid_i;
    assign rd_accept = (state == IDLE) && ar_valid_i && !wr_accept;

    assign addr_ok = (cmd_addr < ADDR_LIMIT);

    // channel handshakes
    assign aw_ready_o = (state == IDLE);
    assign w_ready_o  = (state == IDLE);
    assign ar_ready_o = (state == IDLE);
    assign b_valid_o  = (state == BRESP);
    assign r_valid_o  = (state == RRESP);

    // responses held steady while the master stalls
    assign b_o.id   = cmd_id;
    assign b_o.resp = beat_ok ? OKAY : DECERR;

    assign r_o.data = beat_ok ? mem_rdata_i : '0;
    assign r_o.id   = cmd_id;
    assign r_o.resp = beat_ok ? OKAY : DECERR;
    assign r_o.last = (beats_left == 8'd0);

    // array request suppressed for out of range beats
    always_comb begin
        req_o.en    = ((state == READ) || (state == WRITE)) && addr_ok;
        req_o.we    = (state == WRITE);
        req_o.index = cmd_addr[PMEM_INDEX_W+1:2];
        req_o.wdata = wr_data;
        req_o.strb  = wr_strb;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (wr_accept) begin
                    state_next = WRITE;
                end else if (rd_accept) begin
                    state_next = READ;
                end
            end
            READ: begin
                state_next = RRESP;
            end
            RRESP: begin
                if (r_ready_i) begin
                    state_next = (beats_left == 8'd0) ? IDLE : READ;
                end
            end
            WRITE: begin
                state_next = BRESP;
            end
            BRESP: begin
                if (b_ready_i) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // capture the command then step through the burst
    // FIXED bursts walk the address like INCR
    always_ff @(posedge clock) begin
        if (wr_accept) begin
            cmd_addr <= aw_i.addr;
            cmd_id   <= aw_i.id;
            wr_data  <= w_i.data;
            wr_strb  <= w_i.strb;
        end else if (rd_accept) begin
            cmd_addr   <= ar_i.addr;
            cmd_id     <= ar_i.id;
            beats_left <= ar_i.len;
        end else if ((state == RRESP) && r_ready_i && (beats_left != 8'd0)) begin
            cmd_addr   <= cmd_addr + `PMEM_ADDR_W'(4);
            beats_left <= beats_left - 8'd1;
        end
    end

    // range is sampled once per beat on the request cycle
    always_ff @(posedge clock) begin
        if ((state == READ) || (state == WRITE)) begin
            beat_ok <= addr_ok;
        end
    end

    // single beat writes only
    a_write_single: assert property (
        @(posedge clock) disable iff (reset)
        wr_accept |-> (aw_i.len == 8'd0) && w_i.last
    ) else $error("write burst or missing wlast on accept");

    // full width, non wrapping commands only
    a_write_shape: assert property (
        @(posedge clock) disable iff (reset)
        wr_accept |-> (aw_i.size == FULL_SIZE) && (aw_i.burst != WRAP)
    ) else $error("unsupported AW size or burst type");

    a_read_shape: assert property (
        @(posedge clock) disable iff (reset)
        rd_accept |-> (ar_i.size == FULL_SIZE) && (ar_i.burst != WRAP)
    ) else $error("unsupported AR size or burst type");

    // R and its payload hold until the master takes the beat
    a_r_hold: assert property (
        @(posedge clock) disable iff (reset)
        (r_valid_o && !r_ready_i) |=> r_valid_o && $stable(r_o)
    ) else $error("r_valid or r payload changed without r_ready");

endmodule

`default_nettype wire

/* pmem_params.svh */
`ifndef PMEM_PARAMS_SVH
`define PMEM_PARAMS_SVH

// sizing of the program memory and its AXI4 port

// byte address width on AW and AR
`define PMEM_ADDR_W 32

// data bus width, one word per beat
`define PMEM_DATA_W 32

// AXI transaction id width, echoed on B and R
`define PMEM_ID_W 4

// number of words in the array
// addresses at or above depth*4 decode to DECERR
`define PMEM_DEPTH 1024

`endif

/* pmem_patterns.txt */
# op addr id len data strb resp, all fields hex
# W writes one word, R reads len+1 words, resp 0 is OKAY and 3 is DECERR
# full strobe writes and read back, including the last word
W 00000000 1 00 11223344 f 0
R 00000000 1 00 00000000 0 0
W 00000ffc 2 00 cafef00d f 0
R 00000ffc 3 00 00000000 0 0
# partial strobes
W 00000020 4 00 a5a5a5a5 f 0
W 00000020 5 00 000000ee 1 0
W 00000020 6 00 77000000 8 0
R 00000020 7 00 00000000 0 0
W 00000024 8 00 12345678 f 0
W 00000024 9 00 00bbcc00 6 0
R 00000020 a 01 00000000 0 0
# four beat burst over consecutive words
W 00000100 1 00 10000001 f 0
W 00000104 2 00 20000002 f 0
W 00000108 3 00 30000003 f 0
W 0000010c 4 00 40000004 f 0
R 00000100 b 03 00000000 0 0
# beyond the array, index bits alias word 0
W 00001000 c 00 deadbeef f 3
R 00001000 d 00 00000000 0 3
R 00001ff8 e 02 00000000 0 3
R 00000000 f 00 00000000 0 0
R 00000100 0 03 00000000 0 0

/* pmem_pkg.sv */
`default_nettype none

`include "pmem_params.svh"

package pmem_pkg;

    // word index width into the array
    localparam int PMEM_INDEX_W = $clog2(`PMEM_DEPTH);

    // slave controller states
    // one command in flight, reads loop READ -> RRESP per beat
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        READ  = 3'd1,
        RRESP = 3'd2,
        WRITE = 3'd3,
        BRESP = 3'd4
    } pmem_state_e;

    // request from the controller to the word array
    typedef struct packed {
        logic                      en;
        logic                      we;
        logic [PMEM_INDEX_W-1:0]   index;
        logic [`PMEM_DATA_W-1:0]   wdata;
        logic [`PMEM_DATA_W/8-1:0] strb;
    } pmem_req_t;

endpackage

`default_nettype wire

/* pmem_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pmem_params.svh"

module pmem_sram (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire pmem_pkg::pmem_req_t  req_i,
    output logic [`PMEM_DATA_W-1:0]   rdata_o
);

    localparam int BYTES = `PMEM_DATA_W / 8;

    logic [`PMEM_DATA_W-1:0] mem [`PMEM_DEPTH];

    // byte lane writes leave the read port alone
    always_ff @(posedge clock) begin
        if (req_i.en && req_i.we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (req_i.strb[b]) begin
                    mem[req_i.index][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read that holds the last word between reads
    always_ff @(posedge clock) begin
        if (reset) begin
            rdata_o <= '0;
        end else if (req_i.en && !req_i.we) begin
            rdata_o <= mem[req_i.index];
        end
    end

    // the controller must only issue known indices inside the array
    a_index_range: assert property (
        @(posedge clock) disable iff (reset)
        req_i.en |-> !$isunknown({req_i.we, req_i.index})
                     && (int'(req_i.index) < `PMEM_DEPTH)
    ) else $error("array request with unknown or out of range index");

endmodule

`default_nettype wire

/* pmem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pmem_params.svh"

module pmem_tb;

    import axi_pkg::*;

    localparam int INDEX_W = $clog2(`PMEM_DEPTH);
    localparam logic [`PMEM_ADDR_W-1:0] ADDR_LIMIT = `PMEM_ADDR_W'(`PMEM_DEPTH * 4);

    // one line of the pattern file
    typedef struct packed {
        logic [7:0]                op;
        logic [`PMEM_ADDR_W-1:0]   addr;
        logic [`PMEM_ID_W-1:0]     id;
        logic [7:0]                len;
        logic [`PMEM_DATA_W-1:0]   data;
        logic [`PMEM_DATA_W/8-1:0] strb;
        axi_resp_e                 resp;
    } pattern_t;

    logic    clock;
    logic    reset;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    axi_ar_t ar;
    axi_r_t  r;
    logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic    ar_valid, ar_ready, r_valid, r_ready;

    pattern_t                patterns[$];
    logic [`PMEM_DATA_W-1:0] model [`PMEM_DEPTH];
    logic [31:0]             rng_state;
    int                      errors;
    int                      checks;
    bit                      loaded;

    pmem_tb_clock clock_gen (.clock_o(clock), .reset_o(reset));

    pmem_top dut0 (
        .clock(clock), .reset(reset),
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ready delay of 0 to 3 cycles
    function automatic int draw_delay();
        rng_state = xorshift32(rng_state);
        return int'(rng_state[1:0]);
    endfunction

    // nothing is stored past the array
    function automatic logic [`PMEM_DATA_W-1:0] expected_word(input logic [`PMEM_ADDR_W-1:0] a);
        if (a >= ADDR_LIMIT) begin
            return '0;
        end
        return model[a[INDEX_W+1:2]];
    endfunction

    task automatic model_write(input pattern_t p);
        for (int i = 0; i < `PMEM_DATA_W / 8; i++) begin
            if (p.strb[i]) begin
                model[p.addr[INDEX_W+1:2]][i*8 +: 8] = p.data[i*8 +: 8];
            end
        end
    endtask

    task automatic load_patterns(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr, id, len, data, strb, resp;
        pattern_t    p;
        fd = $fopen("pmem_patterns.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment lines fail the scan after the first field
            n = $sscanf(line, "%c %h %h %h %h %h %h", op, addr, id, len, data, strb, resp);
            if (n == 7 && (op == "W" || op == "R")) begin
                p.op   = op;
                p.addr = addr;
                p.id   = id[`PMEM_ID_W-1:0];
                p.len  = len[7:0];
                p.data = data;
                p.strb = strb[`PMEM_DATA_W/8-1:0];
                p.resp = axi_resp_e'(resp[1:0]);
                patterns.push_back(p);
            end
        end
        if (ok) begin
            $fclose(fd);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] t=%0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_latency(input int got, input int want, input string what);
        checks++;
        if (got != want) begin
            errors++;
            $display("[ERROR] t=%0t: %s took %0d cycles, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_b(input axi_b_t got, input axi_b_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] t=%0t: B id=%h resp=%0d, expected id=%h resp=%0d",
                     $time, got.id, got.resp, want.id, want.resp);
        end
    endtask

    task automatic check_r(input axi_r_t got, input axi_r_t want, input int beat);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] t=%0t: R beat %0d data=%h id=%h resp=%0d last=%b, %s%h %h %0d %b",
                     $time, beat, got.data, got.id, got.resp, got.last, "expected ",
                     want.data, want.id, want.resp, want.last);
        end
    endtask

    task automatic do_write(input pattern_t p);
        int     cycles;
        axi_b_t want;
        @(negedge clock);
        aw       = '{addr: p.addr, id: p.id, len: p.len, size: 3'd2, burst: INCR};
        w        = '{data: p.data, strb: p.strb, last: 1'b1};
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        // ready here holds through the next rising edge
        while (!aw_ready) begin
            @(negedge clock);
        end
        @(negedge clock);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        cycles   = 1;
        while (!b_valid) begin
            @(negedge clock);
            cycles++;
        end
        check_latency(cycles, 2, "write accept to b_valid");
        if (p.addr < ADDR_LIMIT) begin
            model_write(p);
        end
        want = '{id: p.id, resp: p.resp};
        repeat (draw_delay()) begin
            @(negedge clock);
            check_flag(b_valid, 1'b1, "b_valid under back-pressure");
        end
        b_ready = 1'b1;
        check_b(b, want);
        @(negedge clock);
        b_ready = 1'b0;
    endtask

    task automatic do_read(input pattern_t p);
        int                      cycles;
        int                      k;
        logic [`PMEM_ADDR_W-1:0] beat_addr;
        axi_r_t                  want;
        @(negedge clock);
        ar       = '{addr: p.addr, id: p.id, len: p.len, size: 3'd2, burst: INCR};
        ar_valid = 1'b1;
        while (!ar_ready) begin
            @(negedge clock);
        end
        @(negedge clock);
        ar_valid = 1'b0;
        cycles   = 1;
        for (k = 0; k <= int'(p.len); k++) begin
            while (!r_valid) begin
                @(negedge clock);
                cycles++;
            end
            if (k == 0) begin
                check_latency(cycles, 2, "read accept to first r_valid");
            end
            beat_addr = p.addr + `PMEM_ADDR_W'(4 * k);
            want      = '{data: expected_word(beat_addr), id: p.id, resp: p.resp,
                          last: (k == int'(p.len))};
            repeat (draw_delay()) begin
                @(negedge clock);
                check_flag(r_valid, 1'b1, "r_valid under back-pressure");
            end
            r_ready = 1'b1;
            check_r(r, want, k);
            @(negedge clock);
            r_ready = 1'b0;
        end
    endtask

    initial begin
        bit ok;
        aw        = '0;
        w         = '0;
        ar        = '0;
        aw_valid  = 1'b0;
        w_valid   = 1'b0;
        ar_valid  = 1'b0;
        b_ready   = 1'b0;
        r_ready   = 1'b0;
        errors    = 0;
        checks    = 0;
        rng_state = 32'd94;
        loaded    = 1'b0;
        load_patterns(ok);
        if (!ok || patterns.size() == 0) begin
            errors++;
            $display("could not read any patterns from pmem_patterns.txt");
        end else begin
            loaded = 1'b1;
            wait (!reset);
            @(negedge clock);
            // idle port right after reset
            check_flag(aw_ready, 1'b1, "aw_ready after reset");
            check_flag(w_ready, 1'b1, "w_ready after reset");
            check_flag(ar_ready, 1'b1, "ar_ready after reset");
            check_flag(b_valid, 1'b0, "b_valid after reset");
            check_flag(r_valid, 1'b0, "r_valid after reset");
            foreach (patterns[i]) begin
                if (patterns[i].op == "W") begin
                    do_write(patterns[i]);
                end else begin
                    do_read(patterns[i]);
                end
            end
        end
        $display("pmem_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // hang guard scaled by the number of patterns
    initial begin
        wait (loaded);
        repeat (patterns.size() * 300 + 50) @(posedge clock);
        $display("timeout: the DUT stopped responding before all patterns were run");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* pmem_tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module pmem_tb_clock #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clock_o = ~clock_o;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

/* pmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pmem_params.svh"

module pmem_top (
    input  wire logic             clock,
    input  wire logic             reset,

    input  wire axi_pkg::axi_aw_t aw_i,
    input  wire logic             aw_valid_i,
    output logic                  aw_ready_o,

    input  wire axi_pkg::axi_w_t  w_i,
    input  wire logic             w_valid_i,
    output logic                  w_ready_o,

    output axi_pkg::axi_b_t       b_o,
    output logic                  b_valid_o,
    input  wire logic             b_ready_i,

    input  wire axi_pkg::axi_ar_t ar_i,
    input  wire logic             ar_valid_i,
    output logic                  ar_ready_o,

    output axi_pkg::axi_r_t       r_o,
    output logic                  r_valid_o,
    input  wire logic             r_ready_i
);

    import pmem_pkg::*;

    // controller to array
    pmem_req_t               mem_req;
    logic [`PMEM_DATA_W-1:0] mem_rdata;

    pmem_axi_slave u_slave (
        .clock       (clock),
        .reset       (reset),
        .aw_i        (aw_i),
        .aw_valid_i  (aw_valid_i),
        .aw_ready_o  (aw_ready_o),
        .w_i         (w_i),
        .w_valid_i   (w_valid_i),
        .w_ready_o   (w_ready_o),
        .b_o         (b_o),
        .b_valid_o   (b_valid_o),
        .b_ready_i   (b_ready_i),
        .ar_i        (ar_i),
        .ar_valid_i  (ar_valid_i),
        .ar_ready_o  (ar_ready_o),
        .r_o         (r_o),
        .r_valid_o   (r_valid_o),
        .r_ready_i   (r_ready_i),
        .req_o       (mem_req),
        .mem_rdata_i (mem_rdata)
    );

    pmem_sram u_sram (
        .clock   (clock),
        .reset   (reset),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the pmem testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log \
    && verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
        --top-module pmem_tb -o pmem_sim > build.log 2>&1 \
    && ./obj_dir/pmem_sim > sim.log 2>&1
grep -qx "Regression passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
